/* include/mmu_rx_regs_params.svh */
/*
 * MMU receive register block parameters
 * bus widths, block identifier, group codes, register counts per group
 * and the reset values of the configuration registers
 */
`ifndef MMU_RX_REGS_PARAMS_SVH
`define MMU_RX_REGS_PARAMS_SVH

// --------------------
// cpu bus
`define MMU_RX_A_WTH            24
`define MMU_RX_D_WTH            32
`define MMU_RX_BLOCK_ID         12'h001

// --------------------
// group codes, address bits [9:7]
`define MMU_RX_GRP_CFG          3'd0
`define MMU_RX_GRP_ERR          3'd1
`define MMU_RX_GRP_STA          3'd2
`define MMU_RX_GRP_CNT          3'd3

// registers per group
`define MMU_RX_N_CFG            3
`define MMU_RX_N_ERR            4
`define MMU_RX_N_STA            2
`define MMU_RX_N_CNT            7

// --------------------
// configuration reset values
`define MMU_RX_TIMER_1US_INIT   8'd200
`define MMU_RX_TMOUT_US_INIT    16'hffff
`define MMU_RX_RX_CFG_INIT      32'h80000012

`endif

/* design/reg_map_pkg.sv */
/*
 * Register map types
 * splits the 24-bit cpu address into block id, reserved bits, group and
 * index, and carries the decoded access to the register groups
 */
`include "mmu_rx_regs_params.svh"

package reg_map_pkg;

    // index takes what is left below the group field
    localparam int IDX_W = `MMU_RX_A_WTH - 17;

    typedef struct packed {
        logic [11:0]      block_id;
        logic [1:0]       rsvd;
        logic [2:0]       group;
        logic [IDX_W-1:0] index;
    } cpu_addr_t;

    typedef enum logic [2:0] {
        GRP_CFG = `MMU_RX_GRP_CFG,
        GRP_ERR = `MMU_RX_GRP_ERR,
        GRP_STA = `MMU_RX_GRP_STA,
        GRP_CNT = `MMU_RX_GRP_CNT
    } reg_group_e;

    // decoded access, valid in the cycle the address is presented
    typedef struct packed {
        logic                     hit;
        reg_group_e               group;
        logic [IDX_W-1:0]         index;
        logic                     wr_cfg;
        logic                     wr_err;
        logic [`MMU_RX_D_WTH-1:0] wdata;
    } reg_access_t;

endpackage

/* design/mmu_rx_pkg.sv */
/*
 * MMU receive path types
 * error flags, status words, event strobes, configuration outputs
 * and the event counter bank
 */
`include "mmu_rx_regs_params.svh"

package mmu_rx_pkg;

    typedef struct packed {
        logic [31:0] rxbd_err;
        logic [31:0] rxpkt_err;
        logic [15:0] axi_tmout_err;
        logic [31:0] eoc_tag_ff_stat;
    } rx_err_flags_t;

    typedef struct packed {
        logic [31:0] rxbd_sta;
        logic [31:0] rxpkt_sta;
    } rx_status_t;

    // single-cycle strobes, one count each
    typedef struct packed {
        logic [3:0] rxpkt_en;
        logic       txpkt_en;
        logic       rxbd_en;
        logic       rdcmd_en;
    } rx_events_t;

    typedef struct packed {
        logic [7:0]  timer_1us;
        logic [15:0] tmout_us;
        logic [31:0] rx_cfg;
    } rx_cfg_t;

    // 0 rxbd, 1 rdcmd, 2..5 rxpkt0..3, 6 txpkt
    typedef logic [`MMU_RX_N_CNT-1:0][`MMU_RX_D_WTH-1:0] cnt_bank_t;

endpackage

/* design/mmu_rx_addr_decode.sv */
/*
 * Address decode
 * checks block id, reserved bits and the index range of the group,
 * then forms hit and the group write enables
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_addr_decode (
    input  reg_map_pkg::cpu_addr_t    addr,
    input  logic                      wr,
    input  logic [`MMU_RX_D_WTH-1:0]  wdata,
    output reg_map_pkg::reg_access_t  access
);
    import reg_map_pkg::*;

    logic blk_ok;
    logic idx_ok;

    assign blk_ok = (addr.block_id == `MMU_RX_BLOCK_ID) && (addr.rsvd == 2'b00);

    always_comb begin
        access       = '0;
        access.group = reg_group_e'(addr.group);
        access.index = addr.index;
        access.wdata = wdata;

        // holes in the map and groups 4..7 never hit
        case (access.group)
            GRP_CFG: idx_ok = (addr.index < `MMU_RX_N_CFG);
            GRP_ERR: idx_ok = (addr.index < `MMU_RX_N_ERR);
            GRP_STA: idx_ok = (addr.index < `MMU_RX_N_STA);
            GRP_CNT: idx_ok = (addr.index < `MMU_RX_N_CNT);
            default: idx_ok = 1'b0;
        endcase

        access.hit    = blk_ok && idx_ok;
        access.wr_cfg = wr && access.hit && (access.group == GRP_CFG);
        access.wr_err = wr && access.hit && (access.group == GRP_ERR);

        // status and counters are read-only, so only two groups take writes
        assert ($onehot0({access.wr_cfg, access.wr_err}))
            else $error("decode: more than one group write enable");
    end

endmodule

/* design/mmu_rx_cfg_regs.sv */
/*
 * Configuration registers
 * microsecond timer divider, timeout in microseconds and the receive
 * configuration word, written from the cpu and driven out as levels
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_cfg_regs (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  reg_map_pkg::reg_access_t  access,
    output mmu_rx_pkg::rx_cfg_t       cfg
);

    // --------------------
    // register bank
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            cfg.timer_1us <= `MMU_RX_TIMER_1US_INIT;
            cfg.tmout_us  <= `MMU_RX_TMOUT_US_INIT;
            cfg.rx_cfg    <= `MMU_RX_RX_CFG_INIT;
        end else if (access.wr_cfg) begin
            // narrow registers keep the low bits of the write data
            case (access.index)
                7'd0: cfg.timer_1us <= access.wdata[7:0];
                7'd1: cfg.tmout_us  <= access.wdata[15:0];
                7'd2: cfg.rx_cfg    <= access.wdata;
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // checks
    // an X on the cpu data bus would land straight in the config outputs
    a_wdata_known: assert property (
        @(posedge clk_sys) disable iff (rst)
        access.wr_cfg |-> !$isunknown(access.wdata)
    ) else $error("cfg: write data has X while writing");

endmodule

/* design/mmu_rx_err_regs.sv */
/*
 * Sticky error registers
 * each flag bit that is high sets its bit, a cpu write of one clears it,
 * and a set in the same cycle wins over the clear
 */
module mmu_rx_err_regs (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  reg_map_pkg::reg_access_t    access,
    input  mmu_rx_pkg::rx_err_flags_t   flags,
    output mmu_rx_pkg::rx_err_flags_t   err_q
);
    import mmu_rx_pkg::*;

    rx_err_flags_t clr;

    // --------------------
    // write-one-to-clear mask, by index
    always_comb begin
        clr = '0;
        if (access.wr_err) begin
            case (access.index)
                7'd0: clr.rxbd_err        = access.wdata;
                7'd1: clr.rxpkt_err       = access.wdata;
                7'd2: clr.axi_tmout_err   = access.wdata[15:0];
                7'd3: clr.eoc_tag_ff_stat = access.wdata;
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // sticky bits
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            err_q <= '0;
        end else begin
            // clear first, then or in the flags so a live flag survives
            err_q <= (err_q & ~clr) | flags;
        end
    end

endmodule

/* design/mmu_rx_event_cnt.sv */
/*
 * Event counters
 * seven 32-bit counters, one per receive path strobe, with a common
 * clear that wins over increment; counters wrap
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_event_cnt (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  mmu_rx_pkg::rx_events_t  events,
    input  logic                    cnt_reg_clr,
    output mmu_rx_pkg::cnt_bank_t   counts
);

    logic [`MMU_RX_N_CNT-1:0] inc;

    // bank order: rxbd, rdcmd, rxpkt0..3, txpkt
    assign inc = {events.txpkt_en, events.rxpkt_en, events.rdcmd_en, events.rxbd_en};

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            counts <= '0;
        end else if (cnt_reg_clr) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < `MMU_RX_N_CNT; i++) begin
                if (inc[i]) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    // clear must leave every counter at zero, strobes or not
    a_clr_wins: assert property (
        @(posedge clk_sys) disable iff (rst)
        cnt_reg_clr |=> (counts == '0)
    ) else $error("cnt: counter nonzero after clear");

endmodule

/* design/mmu_rx_read_mux.sv */
/*
 * Registered read path
 * stage 1 picks one word per group by index and keeps group and hit,
 * stage 2 picks the group; two cycles from address to data
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_read_mux (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  reg_map_pkg::reg_access_t    access,
    input  mmu_rx_pkg::rx_cfg_t         cfg,
    input  mmu_rx_pkg::rx_err_flags_t   err_q,
    input  mmu_rx_pkg::rx_status_t      status,
    input  mmu_rx_pkg::cnt_bank_t       counts,
    output logic [`MMU_RX_D_WTH-1:0]    cpu_data_out
);
    import reg_map_pkg::*;

    logic [31:0] cfg_word;
    logic [31:0] err_word;
    logic [31:0] sta_word;
    logic [31:0] cnt_word;
    reg_group_e  grp_q;
    logic        hit_q;

    // --------------------
    // stage 1, per-group select
    always_ff @(posedge clk_sys) begin
        case (access.index)
            7'd0: cfg_word <= {24'd0, cfg.timer_1us};
            7'd1: cfg_word <= {16'd0, cfg.tmout_us};
            7'd2: cfg_word <= cfg.rx_cfg;
            default: cfg_word <= '0;
        endcase
        case (access.index)
            7'd0: err_word <= err_q.rxbd_err;
            7'd1: err_word <= err_q.rxpkt_err;
            7'd2: err_word <= {16'd0, err_q.axi_tmout_err};
            7'd3: err_word <= err_q.eoc_tag_ff_stat;
            default: err_word <= '0;
        endcase
        case (access.index)
            7'd0: sta_word <= status.rxbd_sta;
            7'd1: sta_word <= status.rxpkt_sta;
            default: sta_word <= '0;
        endcase
        if (access.index < `MMU_RX_N_CNT) begin
            cnt_word <= counts[access.index[2:0]];
        end else begin
            cnt_word <= '0;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            grp_q <= GRP_CFG;
            hit_q <= 1'b0;
        end else begin
            grp_q <= access.group;
            hit_q <= access.hit;
        end
    end

    // --------------------
    // stage 2, group select
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            cpu_data_out <= '0;
        end else if (!hit_q) begin
            cpu_data_out <= '0;
        end else begin
            case (grp_q)
                GRP_CFG: cpu_data_out <= cfg_word;
                GRP_ERR: cpu_data_out <= err_word;
                GRP_STA: cpu_data_out <= sta_word;
                GRP_CNT: cpu_data_out <= cnt_word;
                default: cpu_data_out <= '0;
            endcase
        end
    end

    // decode only hits defined groups
    a_grp_defined: assert property (
        @(posedge clk_sys) disable iff (rst)
        hit_q |-> (grp_q inside {GRP_CFG, GRP_ERR, GRP_STA, GRP_CNT})
    ) else $error("read: hit on an undefined group code");

endmodule

/* design/mmu_rx_regs.sv */
/*
 * MMU receive register block
 * cpu view of the receive path: configuration, sticky errors, status and
 * event counters, read back through a two-stage registered path
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_regs (
    input  logic                        clk_sys,
    input  logic                        rst,

    // cpu side
    input  reg_map_pkg::cpu_addr_t      cpu_addr,
    input  logic [`MMU_RX_D_WTH-1:0]    cpu_data_in,
    input  logic                        cpu_wr,
    output logic [`MMU_RX_D_WTH-1:0]    cpu_data_out,
    input  logic                        cnt_reg_clr,

    // receive path side
    input  mmu_rx_pkg::rx_err_flags_t   err_flags,
    input  mmu_rx_pkg::rx_status_t      status,
    input  mmu_rx_pkg::rx_events_t      events,
    output mmu_rx_pkg::rx_cfg_t         cfg_out
);
    import reg_map_pkg::*;
    import mmu_rx_pkg::*;

    reg_access_t   access;
    rx_err_flags_t err_q;
    cnt_bank_t     counts;

    // --------------------
    // decode
    mmu_rx_addr_decode decode0 (
        .addr    (cpu_addr),
        .wr      (cpu_wr),
        .wdata   (cpu_data_in),
        .access  (access)
    );

    // --------------------
    // register groups
    mmu_rx_cfg_regs cfg0 (
        .clk_sys (clk_sys),
        .rst     (rst),
        .access  (access),
        .cfg     (cfg_out)
    );

    mmu_rx_err_regs err0 (
        .clk_sys (clk_sys),
        .rst     (rst),
        .access  (access),
        .flags   (err_flags),
        .err_q   (err_q)
    );

    mmu_rx_event_cnt cnt0 (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .events      (events),
        .cnt_reg_clr (cnt_reg_clr),
        .counts      (counts)
    );

    // --------------------
    // read back
    mmu_rx_read_mux read0 (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .access       (access),
        .cfg          (cfg_out),
        .err_q        (err_q),
        .status       (status),
        .counts       (counts),
        .cpu_data_out (cpu_data_out)
    );

endmodule

/* verification/mmu_rx_regs_tb.sv */
/*
 * MMU receive register block testbench
 * drives LFSR traffic through every register group, keeps a model of the
 * block, and compares each read two cycles after its address
 */
`include "mmu_rx_regs_params.svh"

module mmu_rx_regs_tb;
    import reg_map_pkg::*;
    import mmu_rx_pkg::*;

    localparam int PH_LEN       = 300;
    localparam int TOTAL_CYCLES = 2 + 3 + 4 * PH_LEN + 16 + 3 + 2;

    logic          clk_sys;
    logic          rst;
    cpu_addr_t     cpu_addr;
    logic [31:0]   cpu_data_in;
    logic          cpu_wr;
    logic [31:0]   cpu_data_out;
    logic          cnt_reg_clr;
    rx_err_flags_t err_flags;
    rx_status_t    status;
    rx_events_t    events;
    rx_cfg_t       cfg_out;

    // inputs for the next edge
    cpu_addr_t     nx_addr;
    logic          nx_wr;
    logic [31:0]   nx_data;
    rx_err_flags_t nx_flags;
    rx_status_t    nx_status;
    rx_events_t    nx_events;
    logic          nx_clr;

    // model state, cfg slot 3 and counter slot 7 stay unused
    logic [31:0] m_cfg [4];
    logic [31:0] m_err [4];
    logic [31:0] m_cnt [8];
    logic [31:0] exp_q [$];
    logic [31:0] exp_word;
    logic [31:0] lfsr;

    mmu_rx_regs dut0 (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_wr       (cpu_wr),
        .cpu_data_out (cpu_data_out),
        .cnt_reg_clr  (cnt_reg_clr),
        .err_flags    (err_flags),
        .status       (status),
        .events       (events),
        .cfg_out      (cfg_out)
    );

    always #2 clk_sys = ~clk_sys;

    // --------------------
    // random source, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // --------------------
    // reference model
    function automatic int group_size(logic [2:0] grp);
        int n;
        case (grp)
            `MMU_RX_GRP_CFG: n = `MMU_RX_N_CFG;
            `MMU_RX_GRP_ERR: n = `MMU_RX_N_ERR;
            `MMU_RX_GRP_STA: n = `MMU_RX_N_STA;
            `MMU_RX_GRP_CNT: n = `MMU_RX_N_CNT;
            default: n = 0;
        endcase
        return n;
    endfunction

    function automatic logic addr_hits(cpu_addr_t a);
        return (a.block_id == `MMU_RX_BLOCK_ID) && (a.rsvd == 2'b00)
            && (int'(a.index) < group_size(a.group));
    endfunction

    // implemented bits of a writable register
    function automatic logic [31:0] field_mask(logic [2:0] grp, logic [1:0] idx);
        logic [31:0] m;
        m = 32'hffff_ffff;
        if (grp == `MMU_RX_GRP_CFG && idx == 2'd0) begin
            m = 32'h0000_00ff;
        end else if (grp == `MMU_RX_GRP_CFG && idx == 2'd1) begin
            m = 32'h0000_ffff;
        end else if (grp == `MMU_RX_GRP_ERR && idx == 2'd2) begin
            m = 32'h0000_ffff;
        end
        return m;
    endfunction

    function automatic logic [31:0] ref_read(cpu_addr_t a, rx_status_t s);
        logic [31:0] word;
        word = '0;
        if (addr_hits(a)) begin
            case (a.group)
                `MMU_RX_GRP_CFG: word = m_cfg[a.index[1:0]];
                `MMU_RX_GRP_ERR: word = m_err[a.index[1:0]];
                `MMU_RX_GRP_STA: word = a.index[0] ? s.rxpkt_sta : s.rxbd_sta;
                `MMU_RX_GRP_CNT: word = m_cnt[a.index[2:0]];
                default: word = '0;
            endcase
        end
        return word;
    endfunction

    // one clock edge of the block, from the inputs sampled at that edge
    task automatic model_update();
        logic       hit;
        logic [1:0] i2;
        hit = addr_hits(cpu_addr);
        i2  = cpu_addr.index[1:0];
        if (hit && cpu_wr && cpu_addr.group == `MMU_RX_GRP_ERR) begin
            m_err[i2] = m_err[i2] & ~(cpu_data_in & field_mask(`MMU_RX_GRP_ERR, i2));
        end
        // a flag high at the same edge sets its bit again
        m_err[0] = m_err[0] | err_flags.rxbd_err;
        m_err[1] = m_err[1] | err_flags.rxpkt_err;
        m_err[2] = m_err[2] | {16'd0, err_flags.axi_tmout_err};
        m_err[3] = m_err[3] | err_flags.eoc_tag_ff_stat;
        if (hit && cpu_wr && cpu_addr.group == `MMU_RX_GRP_CFG) begin
            m_cfg[i2] = cpu_data_in & field_mask(`MMU_RX_GRP_CFG, i2);
        end
        if (cnt_reg_clr) begin
            m_cnt = '{default: '0};
        end else begin
            if (events.rxbd_en)     m_cnt[0] = m_cnt[0] + 32'd1;
            if (events.rdcmd_en)    m_cnt[1] = m_cnt[1] + 32'd1;
            if (events.rxpkt_en[0]) m_cnt[2] = m_cnt[2] + 32'd1;
            if (events.rxpkt_en[1]) m_cnt[3] = m_cnt[3] + 32'd1;
            if (events.rxpkt_en[2]) m_cnt[4] = m_cnt[4] + 32'd1;
            if (events.rxpkt_en[3]) m_cnt[5] = m_cnt[5] + 32'd1;
            if (events.txpkt_en)    m_cnt[6] = m_cnt[6] + 32'd1;
        end
    endtask

    // --------------------
    // stimulus helpers
    task automatic idle_next();
        nx_addr          = '0;
        nx_addr.block_id = `MMU_RX_BLOCK_ID;
        nx_wr            = 1'b0;
        nx_data          = '0;
        nx_flags         = '0;
        nx_status        = '0;
        nx_events        = '0;
        nx_clr           = 1'b0;
    endtask

    // mostly in range, now and then a wrong block id, reserved bit or index
    task automatic pick_addr(input logic [2:0] grp, output cpu_addr_t a);
        logic [31:0] r;
        int          n;
        n = group_size(grp);
        a.block_id = `MMU_RX_BLOCK_ID;
        a.rsvd     = 2'b00;
        a.group    = grp;
        take_bits(4, r);
        if (r[3:0] == 4'd0) begin
            a.block_id = 12'h0a5;
        end else if (r[3:0] == 4'd1) begin
            a.rsvd = 2'b10;
        end
        take_bits(3, r);
        if (r[2:0] == 3'd0 || n == 0) begin
            take_bits(7, r);
            a.index = r[6:0];
        end else begin
            take_bits(8, r);
            a.index = 7'(r % n);
        end
    endtask

    task automatic sparse_flags(output rx_err_flags_t f);
        logic [31:0] r;
        logic [31:0] s;
        take_bits(32, r);
        take_bits(32, s);
        f.rxbd_err = r & s;
        take_bits(32, r);
        take_bits(32, s);
        f.rxpkt_err = r & s;
        take_bits(32, r);
        f.axi_tmout_err = r[15:0] & r[31:16];
        take_bits(32, r);
        take_bits(32, s);
        f.eoc_tag_ff_stat = r & s;
    endtask

    // expected word is taken from the state before this edge
    task automatic apply_cycle();
        @(posedge clk_sys);
        exp_q.push_back(ref_read(cpu_addr, status));
        model_update();
        cpu_addr    <= nx_addr;
        cpu_wr      <= nx_wr;
        cpu_data_in <= nx_data;
        err_flags   <= nx_flags;
        status      <= nx_status;
        events      <= nx_events;
        cnt_reg_clr <= nx_clr;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // --------------------
    // compare, read data lands two edges after its address
    always @(negedge clk_sys) begin
        if (!rst) begin
            if (exp_q.size() == 2) begin
                exp_word = exp_q.pop_front();
                check_value("cpu_data_out", cpu_data_out, exp_word);
            end
            check_value("cfg_out.timer_1us", {24'd0, cfg_out.timer_1us}, m_cfg[0]);
            check_value("cfg_out.tmout_us", {16'd0, cfg_out.tmout_us}, m_cfg[1]);
            check_value("cfg_out.rx_cfg", cfg_out.rx_cfg, m_cfg[2]);
        end
    end

    initial begin
        #(TOTAL_CYCLES * 4 + 400);
        $display("timeout, the test sequence did not finish in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // test sequence
    initial begin
        logic [31:0] r;
        clk_sys     = 1'b0;
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_wr      = 1'b0;
        cnt_reg_clr = 1'b0;
        err_flags   = '0;
        status      = '0;
        events      = '0;
        lfsr        = 32'h736a;
        m_cfg       = '{default: '0};
        m_err       = '{default: '0};
        m_cnt       = '{default: '0};
        m_cfg[0]    = {24'd0, `MMU_RX_TIMER_1US_INIT};
        m_cfg[1]    = {16'd0, `MMU_RX_TMOUT_US_INIT};
        m_cfg[2]    = `MMU_RX_RX_CFG_INIT;
        idle_next();
        repeat (2) @(posedge clk_sys);
        rst <= 1'b0;
        @(negedge clk_sys);
        check_value("cfg_out.timer_1us", {24'd0, cfg_out.timer_1us}, 32'd200);
        check_value("cfg_out.tmout_us", {16'd0, cfg_out.tmout_us}, 32'h0000_ffff);
        check_value("cfg_out.rx_cfg", cfg_out.rx_cfg, 32'h8000_0012);

        for (int i = 0; i < 3; i++) begin
            idle_next();
            nx_addr.index = 7'(i);
            apply_cycle();
        end

        // configuration writes and reads, with misses
        for (int i = 0; i < PH_LEN; i++) begin
            idle_next();
            pick_addr(`MMU_RX_GRP_CFG, nx_addr);
            take_bits(1, r);
            nx_wr = r[0];
            take_bits(32, nx_data);
            apply_cycle();
        end

        // sticky errors against write-one-to-clear
        for (int i = 0; i < PH_LEN; i++) begin
            idle_next();
            pick_addr(`MMU_RX_GRP_ERR, nx_addr);
            take_bits(1, r);
            nx_wr = r[0];
            take_bits(32, nx_data);
            take_bits(2, r);
            if (r[1:0] == 2'd0) begin
                sparse_flags(nx_flags);
            end
            apply_cycle();
        end

        // event counters, clear lands on busy strobes
        for (int i = 0; i < PH_LEN; i++) begin
            idle_next();
            pick_addr(`MMU_RX_GRP_CNT, nx_addr);
            take_bits(7, r);
            nx_events = rx_events_t'(r[6:0]);
            take_bits(5, r);
            nx_clr = (r[4:0] == 5'd0);
            apply_cycle();
        end

        // every group incl. codes 4..7, status changing each cycle
        for (int i = 0; i < PH_LEN; i++) begin
            idle_next();
            take_bits(3, r);
            pick_addr(r[2:0], nx_addr);
            take_bits(1, r);
            nx_wr = r[0];
            take_bits(32, nx_data);
            take_bits(32, nx_status.rxbd_sta);
            take_bits(32, nx_status.rxpkt_sta);
            take_bits(7, r);
            nx_events = rx_events_t'(r[6:0]);
            take_bits(5, r);
            nx_clr = (r[4:0] == 5'd0);
            take_bits(2, r);
            if (r[1:0] == 2'd0) begin
                sparse_flags(nx_flags);
            end
            apply_cycle();
        end

        // back-to-back sweep over the whole map
        for (int g = 0; g < 4; g++) begin
            for (int i = 0; i < group_size(3'(g)); i++) begin
                idle_next();
                nx_addr.group = 3'(g);
                nx_addr.index = 7'(i);
                take_bits(32, nx_status.rxbd_sta);
                take_bits(32, nx_status.rxpkt_sta);
                take_bits(7, r);
                nx_events = rx_events_t'(r[6:0]);
                apply_cycle();
            end
        end

        // drain the read pipe
        repeat (3) begin
            idle_next();
            apply_cycle();
        end
        @(negedge clk_sys);
        @(posedge clk_sys);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/reg_map_pkg.sv
design/mmu_rx_pkg.sv
design/mmu_rx_addr_decode.sv
design/mmu_rx_cfg_regs.sv
design/mmu_rx_err_regs.sv
design/mmu_rx_event_cnt.sv
design/mmu_rx_read_mux.sv
design/mmu_rx_regs.sv
verification/mmu_rx_regs_tb.sv

/* Makefile */
# Verilator build and run of the MMU receive register block testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := mmu_rx_regs_tb
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
